/* rtl/mine_pkg.sv */
/*
 * Shared definitions for the mine scene view:
 *   coordinate, color and score widths and types
 *   object kind and scene phase enums
 *   background color, kind palette and kind score values
 */
package mine_pkg;

	localparam int coord_x_w = 9;
	localparam int coord_y_w = 8;
	localparam int color_w   = 12;
	localparam int score_w   = 10;

	typedef logic [coord_x_w-1:0] coord_x_t;
	typedef logic [coord_y_w-1:0] coord_y_t;
	typedef logic [color_w-1:0]   color_t;
	typedef logic [score_w-1:0]   score_t;

	typedef enum logic [1:0] {
		kind_gold,
		kind_stone,
		kind_diamond
	} obj_kind_t;

	typedef enum logic [2:0] {
		phase_idle,
		phase_background,
		phase_fetch,
		phase_object,
		phase_next
	} scene_phase_t;

	// dark brown soil
	localparam color_t background_color = 12'h531;

	function automatic color_t kind_color(input obj_kind_t kind);
		case (kind)
			kind_gold:    return 12'hfc0;
			kind_stone:   return 12'h888;
			kind_diamond: return 12'h0ef;
			default:      return 12'hf0f;
		endcase
	endfunction

	function automatic score_t kind_value(input obj_kind_t kind);
		case (kind)
			kind_gold:    return 10'd5;
			kind_stone:   return 10'd1;
			kind_diamond: return 10'd10;
			default:      return 10'd0;
		endcase
	endfunction

endpackage

/* rtl/block_painter.sv */
/*
 * block_painter
 *   rectangle rasterizer, one pixel per cycle, x moving fastest
 *   origin and size are latched on start
 */
`timescale 1ns/1ps

module block_painter (
	input  logic              clk,
	input  logic              resetn,
	input  logic              start,
	input  mine_pkg::coord_x_t origin_x,
	input  mine_pkg::coord_y_t origin_y,
	input  mine_pkg::coord_x_t width,
	input  mine_pkg::coord_y_t height,
	output mine_pkg::coord_x_t px_x,
	output mine_pkg::coord_y_t px_y,
	output logic              px_valid,
	output logic              done
);

	mine_pkg::coord_x_t org_x, blk_w, cnt_x;
	mine_pkg::coord_y_t org_y, blk_h, cnt_y;
	logic active;
	logic last_col;

	assign last_col = (cnt_x == blk_w - 1'b1);

	assign px_x     = org_x + cnt_x;
	assign px_y     = org_y + cnt_y;
	assign px_valid = active;
	assign done     = active && last_col && (cnt_y == blk_h - 1'b1);

	// block geometry, held until the next start
	always_ff @(posedge clk) begin
		if (start) begin
			org_x <= origin_x;
			org_y <= origin_y;
			blk_w <= width;
			blk_h <= height;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			active <= 1'b0;
			cnt_x  <= '0;
			cnt_y  <= '0;
		end else if (start) begin
			active <= 1'b1;
			cnt_x  <= '0;
			cnt_y  <= '0;
		end else if (active) begin
			if (done) begin
				active <= 1'b0;
			end else if (last_col) begin
				// wrap to the start of the next row
				cnt_x <= '0;
				cnt_y <= cnt_y + 1'b1;
			end else begin
				cnt_x <= cnt_x + 1'b1;
			end
		end
	end

endmodule

/* rtl/object_table.sv */
/*
 * object_table
 *   per-object position, kind and visibility registers
 *   load port (blocked while locked), collect port, combinational read port
 */
`timescale 1ns/1ps

module object_table #(
	parameter int num_objects = 8
) (
	input  logic                           clk,
	input  logic                           resetn,
	input  logic                           load_en,
	input  logic [$clog2(num_objects)-1:0] load_index,
	input  mine_pkg::coord_x_t             load_x,
	input  mine_pkg::coord_y_t             load_y,
	input  mine_pkg::obj_kind_t            load_kind,
	input  logic                           load_visible,
	input  logic                           locked,
	input  logic                           collect_en,
	input  logic [$clog2(num_objects)-1:0] collect_index,
	input  logic [$clog2(num_objects)-1:0] read_index,
	output mine_pkg::coord_x_t             obj_x,
	output mine_pkg::coord_y_t             obj_y,
	output mine_pkg::obj_kind_t            obj_kind,
	output logic                           obj_visible,
	output logic                           collect_hit,
	output mine_pkg::obj_kind_t            collect_kind
);

	mine_pkg::coord_x_t  x_r    [num_objects];
	mine_pkg::coord_y_t  y_r    [num_objects];
	mine_pkg::obj_kind_t kind_r [num_objects];
	logic [num_objects-1:0] vis_r;
	logic load_ok;

	assign load_ok = load_en && !locked;

	assign obj_x       = x_r[read_index];
	assign obj_y       = y_r[read_index];
	assign obj_kind    = kind_r[read_index];
	assign obj_visible = vis_r[read_index];

	// only a visible object can be collected, and only once
	assign collect_hit  = collect_en && vis_r[collect_index];
	assign collect_kind = kind_r[collect_index];

	always_ff @(posedge clk) begin
		if (load_ok) begin
			x_r[load_index]    <= load_x;
			y_r[load_index]    <= load_y;
			kind_r[load_index] <= load_kind;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			vis_r <= '0;
		end else begin
			if (load_ok) begin
				vis_r[load_index] <= load_visible;
			end
			// collect wins over a load to the same slot
			if (collect_hit) begin
				vis_r[collect_index] <= 1'b0;
			end
		end
	end

endmodule

/* rtl/scene_controller.sv */
/*
 * scene_controller
 *   frame FSM: background fill, then one block per visible object
 *   object index walk and block color selection
 *   registered pixel outputs
 */
`timescale 1ns/1ps

module scene_controller #(
	parameter int num_objects = 8,
	parameter int screen_w    = 320,
	parameter int screen_h    = 240,
	parameter int block_size  = 16
) (
	input  logic                           clk,
	input  logic                           resetn,
	input  logic                           go,
	input  logic                           game_end,
	input  mine_pkg::coord_x_t             obj_x,
	input  mine_pkg::coord_y_t             obj_y,
	input  mine_pkg::obj_kind_t            obj_kind,
	input  logic                           obj_visible,
	input  mine_pkg::coord_x_t             px_x,
	input  mine_pkg::coord_y_t             px_y,
	input  logic                           px_valid,
	input  logic                           painter_done,
	output logic                           painter_start,
	output mine_pkg::coord_x_t             origin_x,
	output mine_pkg::coord_y_t             origin_y,
	output mine_pkg::coord_x_t             width,
	output mine_pkg::coord_y_t             height,
	output logic [$clog2(num_objects)-1:0] read_index,
	output logic                           frame_start,
	output logic                           busy,
	output mine_pkg::coord_x_t             x_out,
	output mine_pkg::coord_y_t             y_out,
	output mine_pkg::color_t               color_out,
	output logic                           write_en
);

	localparam int idx_w = $clog2(num_objects);

	mine_pkg::scene_phase_t phase;
	logic [idx_w-1:0] obj_idx;
	mine_pkg::color_t cur_color;
	logic accept;
	logic last_obj;

	assign accept   = (phase == mine_pkg::phase_idle) && go && !game_end;
	assign last_obj = (obj_idx == idx_w'(num_objects - 1));

	assign read_index  = obj_idx;
	assign frame_start = accept;
	// phase_next covers the cycle of the last registered pixel
	assign busy = (phase != mine_pkg::phase_idle);

	always_comb begin
		painter_start = 1'b0;
		origin_x      = '0;
		origin_y      = '0;
		width         = mine_pkg::coord_x_t'(screen_w);
		height        = mine_pkg::coord_y_t'(screen_h);
		if (accept) begin
			// full screen fill from 0,0
			painter_start = 1'b1;
		end else if (phase == mine_pkg::phase_fetch && obj_visible) begin
			painter_start = 1'b1;
			origin_x      = obj_x;
			origin_y      = obj_y;
			width         = mine_pkg::coord_x_t'(block_size);
			height        = mine_pkg::coord_y_t'(block_size);
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			phase   <= mine_pkg::phase_idle;
			obj_idx <= '0;
		end else begin
			case (phase)
				mine_pkg::phase_idle: begin
					if (accept) begin
						phase   <= mine_pkg::phase_background;
						obj_idx <= '0;
					end
				end
				mine_pkg::phase_background: begin
					if (painter_done) begin
						phase <= mine_pkg::phase_fetch;
					end
				end
				mine_pkg::phase_fetch: begin
					// invisible objects skip straight on
					if (obj_visible) begin
						phase <= mine_pkg::phase_object;
					end else begin
						phase <= mine_pkg::phase_next;
					end
				end
				mine_pkg::phase_object: begin
					if (painter_done) begin
						phase <= mine_pkg::phase_next;
					end
				end
				mine_pkg::phase_next: begin
					if (last_obj) begin
						phase <= mine_pkg::phase_idle;
					end else begin
						obj_idx <= obj_idx + 1'b1;
						phase   <= mine_pkg::phase_fetch;
					end
				end
				default: phase <= mine_pkg::phase_idle;
			endcase
		end
	end

	// color of the block currently being painted
	always_ff @(posedge clk) begin
		if (accept) begin
			cur_color <= mine_pkg::background_color;
		end else if (phase == mine_pkg::phase_fetch) begin
			cur_color <= mine_pkg::kind_color(obj_kind);
		end
	end

	// output stage, one cycle behind the painter
	always_ff @(posedge clk) begin
		x_out     <= px_x;
		y_out     <= px_y;
		color_out <= cur_color;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			write_en <= 1'b0;
		end else begin
			write_en <= px_valid;
		end
	end

endmodule

/* rtl/game_status.sv */
/*
 * game_status
 *   tick prescaler and seconds countdown, started by the first frame
 *   score accumulator for collected objects
 *   next level flag and game end
 */
`timescale 1ns/1ps

module game_status #(
	parameter int tick_cycles  = 50_000_000,
	parameter int game_seconds = 60,
	parameter int goal         = 50
) (
	input  logic                clk,
	input  logic                resetn,
	input  logic                frame_start,
	input  logic                collect_hit,
	input  mine_pkg::obj_kind_t collect_kind,
	output mine_pkg::score_t    score,
	output logic [7:0]          time_left,
	output logic                next_level,
	output logic                game_end
);

	localparam int tick_w = (tick_cycles > 1) ? $clog2(tick_cycles) : 1;

	logic [tick_w-1:0] tick_cnt;
	logic running;
	logic tick;

	assign tick     = (tick_cnt == tick_w'(tick_cycles - 1));
	assign game_end = (time_left == 8'd0);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			running <= 1'b0;
		end else if (frame_start) begin
			running <= 1'b1;
		end
	end

	// countdown freezes once it hits zero
	always_ff @(posedge clk) begin
		if (!resetn) begin
			tick_cnt  <= '0;
			time_left <= 8'(game_seconds);
		end else if (running && !game_end) begin
			if (tick) begin
				tick_cnt  <= '0;
				time_left <= time_left - 8'd1;
			end else begin
				tick_cnt <= tick_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			score      <= '0;
			next_level <= 1'b0;
		end else begin
			if (collect_hit) begin
				score <= score + mine_pkg::kind_value(collect_kind);
			end
			next_level <= (score >= mine_pkg::score_t'(goal));
		end
	end

endmodule

/* rtl/mine_view.sv */
/*
 * mine_view
 *   top level of the scene view
 *   object table, scene FSM, block painter and game status
 */
`timescale 1ns/1ps

module mine_view #(
	parameter int num_objects  = 8,
	parameter int screen_w     = 320,
	parameter int screen_h     = 240,
	parameter int block_size   = 16,
	parameter int tick_cycles  = 50_000_000,
	parameter int game_seconds = 60,
	parameter int goal         = 50
) (
	input  logic                           clk,
	input  logic                           resetn,
	input  logic                           go,
	input  logic                           load_en,
	input  logic [$clog2(num_objects)-1:0] load_index,
	input  mine_pkg::coord_x_t             load_x,
	input  mine_pkg::coord_y_t             load_y,
	input  mine_pkg::obj_kind_t            load_kind,
	input  logic                           load_visible,
	input  logic                           collect_en,
	input  logic [$clog2(num_objects)-1:0] collect_index,
	output mine_pkg::coord_x_t             x_out,
	output mine_pkg::coord_y_t             y_out,
	output mine_pkg::color_t               color_out,
	output logic                           write_en,
	output logic                           busy,
	output mine_pkg::score_t               score,
	output logic [7:0]                     time_left,
	output logic                           next_level,
	output logic                           game_end
);

	localparam int idx_w = $clog2(num_objects);

	logic [idx_w-1:0] read_index;
	mine_pkg::coord_x_t obj_x, origin_x, width, px_x;
	mine_pkg::coord_y_t obj_y, origin_y, height, px_y;
	mine_pkg::obj_kind_t obj_kind, collect_kind;
	logic obj_visible, collect_hit, frame_start;
	logic painter_start, px_valid, painter_done;

	// table is frozen for the whole frame
	object_table #(
		.num_objects(num_objects)
	) i_object_table (
		.clk(clk),
		.resetn(resetn),
		.load_en(load_en),
		.load_index(load_index),
		.load_x(load_x),
		.load_y(load_y),
		.load_kind(load_kind),
		.load_visible(load_visible),
		.locked(busy),
		.collect_en(collect_en),
		.collect_index(collect_index),
		.read_index(read_index),
		.obj_x(obj_x),
		.obj_y(obj_y),
		.obj_kind(obj_kind),
		.obj_visible(obj_visible),
		.collect_hit(collect_hit),
		.collect_kind(collect_kind)
	);

	scene_controller #(
		.num_objects(num_objects),
		.screen_w(screen_w),
		.screen_h(screen_h),
		.block_size(block_size)
	) i_scene_controller (
		.clk(clk),
		.resetn(resetn),
		.go(go),
		.game_end(game_end),
		.obj_x(obj_x),
		.obj_y(obj_y),
		.obj_kind(obj_kind),
		.obj_visible(obj_visible),
		.px_x(px_x),
		.px_y(px_y),
		.px_valid(px_valid),
		.painter_done(painter_done),
		.painter_start(painter_start),
		.origin_x(origin_x),
		.origin_y(origin_y),
		.width(width),
		.height(height),
		.read_index(read_index),
		.frame_start(frame_start),
		.busy(busy),
		.x_out(x_out),
		.y_out(y_out),
		.color_out(color_out),
		.write_en(write_en)
	);

	block_painter i_block_painter (
		.clk(clk),
		.resetn(resetn),
		.start(painter_start),
		.origin_x(origin_x),
		.origin_y(origin_y),
		.width(width),
		.height(height),
		.px_x(px_x),
		.px_y(px_y),
		.px_valid(px_valid),
		.done(painter_done)
	);

	game_status #(
		.tick_cycles(tick_cycles),
		.game_seconds(game_seconds),
		.goal(goal)
	) i_game_status (
		.clk(clk),
		.resetn(resetn),
		.frame_start(frame_start),
		.collect_hit(collect_hit),
		.collect_kind(collect_kind),
		.score(score),
		.time_left(time_left),
		.next_level(next_level),
		.game_end(game_end)
	);

endmodule

/* sim/tb_mine_model.svh */
/*
 * Testbench model of the mine scene view:
 *   copy of the object table and the score
 *   palette and score value of each kind
 *   expected pixel queue of one frame
 */
`ifndef TB_MINE_MODEL_SVH
`define TB_MINE_MODEL_SVH

// soil fill, then gold, stone and diamond
localparam logic [11:0] rgb_background = 12'h531;
localparam logic [11:0] rgb_gold       = 12'hfc0;
localparam logic [11:0] rgb_stone      = 12'h888;
localparam logic [11:0] rgb_diamond    = 12'h0ef;

logic [8:0] m_x    [n_obj];
logic [7:0] m_y    [n_obj];
logic [1:0] m_kind [n_obj];
logic       m_vis  [n_obj];
int         m_score;

// expected pixels as {x, y, color}
logic [28:0] exp_q [$];

// kind codes follow the enum order gold, stone, diamond
function automatic logic [11:0] palette_of(input logic [1:0] kind);
	case (kind)
		2'd0:    return rgb_gold;
		2'd1:    return rgb_stone;
		default: return rgb_diamond;
	endcase
endfunction

function automatic int points_of(input logic [1:0] kind);
	case (kind)
		2'd0:    return 5;
		2'd1:    return 1;
		default: return 10;
	endcase
endfunction

task automatic clear_model();
	exp_q.delete();
	m_score = 0;
	for (int i = 0; i < n_obj; i++) begin
		m_x[i]    = '0;
		m_y[i]    = '0;
		m_kind[i] = '0;
		m_vis[i]  = 1'b0;
	end
endtask

task automatic store_object(input int idx, input logic [8:0] x, input logic [7:0] y,
		input logic [1:0] kind, input logic vis);
	m_x[idx]    = x;
	m_y[idx]    = y;
	m_kind[idx] = kind;
	m_vis[idx]  = vis;
endtask

task automatic take_object(input int idx);
	m_score    = m_score + points_of(m_kind[idx]);
	m_vis[idx] = 1'b0;
endtask

// background raster first, then visible blocks in index order
task automatic build_frame();
	logic [8:0] px;
	logic [7:0] py;
	exp_q.delete();
	for (int r = 0; r < scr_h; r++) begin
		for (int c = 0; c < scr_w; c++) begin
			exp_q.push_back({9'(c), 8'(r), rgb_background});
		end
	end
	for (int i = 0; i < n_obj; i++) begin
		if (m_vis[i]) begin
			for (int r = 0; r < blk; r++) begin
				for (int c = 0; c < blk; c++) begin
					px = m_x[i] + 9'(c);
					py = m_y[i] + 8'(r);
					exp_q.push_back({px, py, palette_of(m_kind[i])});
				end
			end
		end
	end
endtask

`endif

/* sim/tb_mine_view.sv */
/*
 * Testbench for the mine scene view:
 *   clock, reset and xorshift stimulus
 *   per-cycle checks of pixels, busy, score, next level and timer
 *   watchdog and closing report
 */
`timescale 1ns/1ps

module tb_mine_view;

	localparam int n_obj   = 8;
	localparam int scr_w   = 16;
	localparam int scr_h   = 12;
	localparam int blk     = 3;
	localparam int tick    = 200;
	localparam int seconds = 40;
	localparam int goal    = 30;
	localparam int cycle_limit = seconds * tick + 4000;

	logic clk;
	logic resetn;
	logic go;
	logic load_en;
	logic [2:0] load_index;
	mine_pkg::coord_x_t load_x;
	mine_pkg::coord_y_t load_y;
	mine_pkg::obj_kind_t load_kind;
	logic load_visible;
	logic collect_en;
	logic [2:0] collect_index;
	mine_pkg::coord_x_t x_out;
	mine_pkg::coord_y_t y_out;
	mine_pkg::color_t color_out;
	logic write_en;
	logic busy;
	mine_pkg::score_t score;
	logic [7:0] time_left;
	logic next_level;
	logic game_end;

	logic [31:0] rng_state;
	int errors;
	int cycle_count;
	int elapsed;
	int exp_time;
	logic timer_running;
	logic frame_active;

	`include "tb_mine_model.svh"

	mine_view #(
		.num_objects(n_obj),
		.screen_w(scr_w),
		.screen_h(scr_h),
		.block_size(blk),
		.tick_cycles(tick),
		.game_seconds(seconds),
		.goal(goal)
	) i_mine_view (
		.clk(clk),
		.resetn(resetn),
		.go(go),
		.load_en(load_en),
		.load_index(load_index),
		.load_x(load_x),
		.load_y(load_y),
		.load_kind(load_kind),
		.load_visible(load_visible),
		.collect_en(collect_en),
		.collect_index(collect_index),
		.x_out(x_out),
		.y_out(y_out),
		.color_out(color_out),
		.write_en(write_en),
		.busy(busy),
		.score(score),
		.time_left(time_left),
		.next_level(next_level),
		.game_end(game_end)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
	end

	initial begin : watchdog
		wait (cycle_count > cycle_limit);
		$display("timeout: run did not finish within %0d cycles", cycle_limit);
		$display("TB FAILED");
		$finish;
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	task automatic report_mismatch(input string msg);
		errors++;
		$display("ERR %0t: %s", $time, msg);
	endtask

	// update the model from the inputs, clock once, then check outputs 2 ns later
	task automatic advance_cycle();
		logic accept;
		logic hit;
		logic l_en;
		int l_idx;
		int c_idx;
		int s_prev;
		logic [28:0] exp;
		accept = go && !frame_active && (exp_time != 0);
		hit    = collect_en && m_vis[collect_index];
		l_en   = load_en && !frame_active;
		l_idx  = load_index;
		c_idx  = collect_index;
		s_prev = m_score;
		if (l_en) begin
			store_object(l_idx, load_x, load_y, load_kind, load_visible);
		end
		// a collect beats a load to the same slot
		if (hit) begin
			take_object(c_idx);
		end
		if (timer_running) begin
			elapsed++;
		end else if (accept) begin
			timer_running = 1'b1;
			elapsed = 0;
		end
		if (elapsed / tick >= seconds) begin
			exp_time = 0;
		end else begin
			exp_time = seconds - elapsed / tick;
		end
		@(posedge clk);
		#2;
		if (accept) begin
			build_frame();
			frame_active = 1'b1;
		end
		if (int'(score) != m_score) begin
			report_mismatch($sformatf("score %0d, expected %0d", score, m_score));
		end
		if (next_level != (s_prev >= goal)) begin
			report_mismatch($sformatf("next_level %0b with score %0d", next_level, s_prev));
		end
		if (int'(time_left) != exp_time) begin
			report_mismatch($sformatf("time_left %0d, expected %0d", time_left, exp_time));
		end
		if (game_end != (exp_time == 0)) begin
			report_mismatch($sformatf("game_end %0b at time_left %0d", game_end, exp_time));
		end
		if (write_en) begin
			if (!busy) begin
				report_mismatch("write_en high while busy is low");
			end
			if (exp_q.size() == 0) begin
				report_mismatch($sformatf("extra pixel %0d,%0d", x_out, y_out));
			end else begin
				exp = exp_q.pop_front();
				if ({x_out, y_out, color_out} != exp) begin
					report_mismatch($sformatf("pixel %0d,%0d %03h, expected %0d,%0d %03h",
						x_out, y_out, color_out, exp[28:20], exp[19:12], exp[11:0]));
				end
			end
		end
		if (frame_active && !busy) begin
			if (exp_q.size() != 0) begin
				report_mismatch($sformatf("busy fell with %0d pixels missing", exp_q.size()));
			end
			frame_active = 1'b0;
		end else if (!frame_active && busy) begin
			report_mismatch("busy high with no frame running");
		end
	endtask

	task automatic load_random(input int idx, input logic vis);
		load_en      = 1'b1;
		load_index   = 3'(idx);
		load_x       = 9'(next_rand() % (scr_w - blk + 1));
		load_y       = 8'(next_rand() % (scr_h - blk + 1));
		load_kind    = mine_pkg::obj_kind_t'(next_rand() % 3);
		load_visible = vis;
		advance_cycle();
		load_en = 1'b0;
	endtask

	task automatic run_frame();
		go = 1'b1;
		advance_cycle();
		go = 1'b0;
		while (frame_active) begin
			advance_cycle();
		end
	endtask

	task automatic collect_at(input int idx);
		collect_en    = 1'b1;
		collect_index = 3'(idx);
		advance_cycle();
		collect_en = 1'b0;
	endtask

	initial begin
		rng_state     = 32'h90f7_204d;
		resetn        = 1'b0;
		go            = 1'b0;
		load_en       = 1'b0;
		load_index    = '0;
		load_x        = '0;
		load_y        = '0;
		load_kind     = mine_pkg::kind_gold;
		load_visible  = 1'b0;
		collect_en    = 1'b0;
		collect_index = '0;
		errors        = 0;
		cycle_count   = 0;
		elapsed       = 0;
		exp_time      = seconds;
		timer_running = 1'b0;
		frame_active  = 1'b0;
		clear_model();
		repeat (16) @(posedge clk);
		#2;
		resetn = 1'b1;
		if (write_en || busy || next_level || game_end || score != 0
				|| time_left != 8'(seconds)) begin
			report_mismatch("outputs not at their reset values");
		end
		for (int i = 0; i < n_obj; i++) begin
			load_random(i, (next_rand() % 4) != 0);
		end
		run_frame();
		// loads while busy must not reach the table
		go = 1'b1;
		advance_cycle();
		go = 1'b0;
		while (frame_active) begin
			load_en      = 1'b1;
			load_index   = 3'(next_rand() % n_obj);
			load_x       = 9'(next_rand() % scr_w);
			load_y       = 8'(next_rand() % scr_h);
			load_kind    = mine_pkg::obj_kind_t'(next_rand() % 3);
			load_visible = 1'(next_rand() % 2);
			advance_cycle();
		end
		load_en = 1'b0;
		run_frame();
		for (int round = 0; round < 8 && m_score < goal; round++) begin
			for (int i = 0; i < n_obj; i++) begin
				load_random(i, 1'b1);
			end
			run_frame();
			for (int i = 0; i < n_obj; i++) begin
				if ((next_rand() % 4) != 0) begin
					collect_at(i);
					// second collect of the same object scores nothing
					collect_at(i);
				end
			end
			run_frame();
		end
		if (m_score < goal) begin
			report_mismatch("stimulus never reached the goal score");
		end
		while (exp_time != 0) begin
			advance_cycle();
		end
		repeat (4) advance_cycle();
		go = 1'b1;
		advance_cycle();
		go = 1'b0;
		repeat (10) advance_cycle();
		if (!game_end || busy) begin
			report_mismatch("game over state not held after a late go");
		end
		$display("errors: %0d, cycles: %0d", errors, cycle_count);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

/* flist.f */
+incdir+sim
rtl/mine_pkg.sv
rtl/block_painter.sv
rtl/object_table.sv
rtl/scene_controller.sv
rtl/game_status.sv
rtl/mine_view.sv
sim/tb_mine_view.sv
